// File: source/serial_pkg.sv
package serial_pkg;

   // Serial pass length, one bit per clock
   localparam int WORD_W = 32;

   // Largest cluster the rotation logic is sized for
   localparam int MAX_LANES = 8;

   typedef logic [WORD_W-1:0] word_t;

   // Bit position within a serial pass
   typedef logic [4:0] bitcnt_t;

   // Code 7 is left free and yields zero
   typedef enum logic [2:0] {
      OP_ADD  = 3'd0,
      OP_SUB  = 3'd1,
      OP_AND  = 3'd2,
      OP_OR   = 3'd3,
      OP_XOR  = 3'd4,
      OP_SLT  = 3'd5,
      OP_SLTU = 3'd6
   } op_t;

endpackage

// File: source/serial_dispatch.sv
module serial_dispatch #(
   parameter int N_LANES = 4
) (
   input  logic               clk,
   input  logic               i_rst,
   input  logic               i_cmd_valid,
   output logic               o_cmd_ready,
   input  logic [N_LANES-1:0] i_lane_idle,
   output logic [N_LANES-1:0] o_start
);

   localparam int PTR_W = (N_LANES > 1) ? $clog2(N_LANES) : 1;

   logic [PTR_W-1:0] ptr;
   logic             accept;

   if ((N_LANES < 1) || (N_LANES > serial_pkg::MAX_LANES)) begin : g_lane_check
      $error("N_LANES out of range");
   end

   // Only the lane under the pointer may take the next command
   assign o_cmd_ready = i_lane_idle[ptr];
   assign accept      = i_cmd_valid & o_cmd_ready;

   always_comb begin
      o_start = '0;
      if (accept) begin
         o_start[ptr] = 1'b1;
      end
   end

   always_ff @(posedge clk) begin
      if (i_rst) begin
         ptr <= '0;
      end else if (accept) begin
         if (ptr == PTR_W'(N_LANES - 1)) begin
            ptr <= '0;
         end else begin
            ptr <= ptr + PTR_W'(1);
         end
      end
   end

   // A started lane leaves idle on the next edge
   a_start_leaves_idle: assert property (
      @(posedge clk) disable iff (i_rst)
      (o_start != '0) |=> ((i_lane_idle & $past(o_start)) == '0)
   );

endmodule

// File: source/serial_lane.sv
module serial_lane (
   input  logic              clk,
   input  logic              i_rst,
   input  logic              i_start,
   input  serial_pkg::op_t   i_op,
   input  serial_pkg::word_t i_a,
   input  serial_pkg::word_t i_b,
   output logic              o_idle,
   input  logic              i_take,
   output logic              o_done,
   output serial_pkg::word_t o_result
);

   typedef enum logic [1:0] {
      IDLE,
      RUN,
      DONE
   } state_t;

   state_t              state;
   serial_pkg::bitcnt_t cnt;
   serial_pkg::op_t     op_q;
   serial_pkg::word_t   a_sr;
   serial_pkg::word_t   b_sr;
   serial_pkg::word_t   res_sr;
   logic                carry;

   logic a_bit;
   logic b_raw;
   logic b_bit;
   logic sum;
   logic cout;
   logic res_bit;
   logic lt;
   logic is_cmp;
   logic last;

   // Operations that run the adder as a - b
   function automatic logic sub_like(input serial_pkg::op_t op);
      return (op == serial_pkg::OP_SUB) || (op == serial_pkg::OP_SLT) ||
             (op == serial_pkg::OP_SLTU);
   endfunction

   assign a_bit = a_sr[0];
   assign b_raw = b_sr[0];
   assign b_bit = b_raw ^ sub_like(op_q);

   // Single full-adder slice
   assign sum  = a_bit ^ b_bit ^ carry;
   assign cout = (a_bit & b_bit) | (carry & (a_bit ^ b_bit));

   assign is_cmp = (op_q == serial_pkg::OP_SLT) || (op_q == serial_pkg::OP_SLTU);
   assign last   = (cnt == serial_pkg::bitcnt_t'(serial_pkg::WORD_W - 1));

   // No carry out of a + ~b + 1 means a < b unsigned, sign bits flip it for slt
   assign lt = (op_q == serial_pkg::OP_SLT) ? (~cout ^ a_bit ^ b_raw) : ~cout;

   always_comb begin
      case (op_q)
         serial_pkg::OP_ADD,
         serial_pkg::OP_SUB: res_bit = sum;
         serial_pkg::OP_AND: res_bit = a_bit & b_raw;
         serial_pkg::OP_OR:  res_bit = a_bit | b_raw;
         serial_pkg::OP_XOR: res_bit = a_bit ^ b_raw;
         default:            res_bit = 1'b0;
      endcase
   end

   always_ff @(posedge clk) begin
      if (i_rst) begin
         state <= IDLE;
         cnt   <= '0;
      end else begin
         case (state)
            IDLE: begin
               if (i_start) begin
                  state <= RUN;
                  cnt   <= '0;
               end
            end
            RUN: begin
               cnt <= cnt + serial_pkg::bitcnt_t'(1);
               if (last) begin
                  state <= DONE;
               end
            end
            DONE: begin
               if (i_take) begin
                  state <= IDLE;
               end
            end
            default: state <= IDLE;
         endcase
      end
   end

   always_ff @(posedge clk) begin
      if ((state == IDLE) && i_start) begin
         op_q  <= i_op;
         a_sr  <= i_a;
         b_sr  <= i_b;
         carry <= sub_like(i_op);
      end else if (state == RUN) begin
         a_sr  <= {1'b0, a_sr[serial_pkg::WORD_W-1:1]};
         b_sr  <= {1'b0, b_sr[serial_pkg::WORD_W-1:1]};
         carry <= cout;
         if (last && is_cmp) begin
            res_sr <= serial_pkg::word_t'(lt);
         end else begin
            // Result fills from the top, LSB ends up at bit 0
            res_sr <= {res_bit, res_sr[serial_pkg::WORD_W-1:1]};
         end
      end
   end

   assign o_idle   = (state == IDLE);
   assign o_done   = (state == DONE);
   assign o_result = res_sr;

   a_start_when_idle: assert property (
      @(posedge clk) disable iff (i_rst) i_start |-> (state == IDLE)
   );

   a_take_when_done: assert property (
      @(posedge clk) disable iff (i_rst) i_take |-> (state == DONE)
   );

endmodule

// File: source/serial_collect.sv
module serial_collect #(
   parameter int N_LANES = 4
) (
   input  logic                                  clk,
   input  logic                                  i_rst,
   input  logic              [N_LANES-1:0]       i_lane_done,
   input  serial_pkg::word_t [N_LANES-1:0]       i_lane_result,
   output logic                                  o_res_valid,
   input  logic                                  i_res_ready,
   output serial_pkg::word_t                     o_res_data,
   output logic              [N_LANES-1:0]       o_take
);

   localparam int PTR_W = (N_LANES > 1) ? $clog2(N_LANES) : 1;

   logic [PTR_W-1:0] ptr;
   logic             xfer;

   // Drain in the same rotation the dispatcher fills
   assign o_res_valid = i_lane_done[ptr];
   assign o_res_data  = i_lane_result[ptr];
   assign xfer        = o_res_valid & i_res_ready;

   always_comb begin
      o_take = '0;
      if (xfer) begin
         o_take[ptr] = 1'b1;
      end
   end

   always_ff @(posedge clk) begin
      if (i_rst) begin
         ptr <= '0;
      end else if (xfer) begin
         if (ptr == PTR_W'(N_LANES - 1)) begin
            ptr <= '0;
         end else begin
            ptr <= ptr + PTR_W'(1);
         end
      end
   end

   // Stalled result must hold until it is taken
   a_res_stable: assert property (
      @(posedge clk) disable iff (i_rst)
      (o_res_valid && !i_res_ready) |=> (o_res_valid && $stable(o_res_data))
   );

endmodule

// File: source/serial_cluster.sv
module serial_cluster #(
   parameter int N_LANES = 4
) (
   input  logic              clk,
   input  logic              i_rst,
   input  logic              i_cmd_valid,
   output logic              o_cmd_ready,
   input  serial_pkg::op_t   i_cmd_op,
   input  serial_pkg::word_t i_cmd_a,
   input  serial_pkg::word_t i_cmd_b,
   output logic              o_res_valid,
   input  logic              i_res_ready,
   output serial_pkg::word_t o_res_data
);

   logic              [N_LANES-1:0] lane_idle;
   logic              [N_LANES-1:0] lane_start;
   logic              [N_LANES-1:0] lane_done;
   logic              [N_LANES-1:0] lane_take;
   serial_pkg::word_t [N_LANES-1:0] lane_result;

   serial_dispatch #(
      .N_LANES (N_LANES)
   ) i_serial_dispatch (
      .clk         (clk),
      .i_rst       (i_rst),
      .i_cmd_valid (i_cmd_valid),
      .o_cmd_ready (o_cmd_ready),
      .i_lane_idle (lane_idle),
      .o_start     (lane_start)
   );

   // Operation and operands go to every lane, start selects one
   for (genvar g = 0; g < N_LANES; g++) begin : g_lane
      serial_lane i_serial_lane (
         .clk      (clk),
         .i_rst    (i_rst),
         .i_start  (lane_start[g]),
         .i_op     (i_cmd_op),
         .i_a      (i_cmd_a),
         .i_b      (i_cmd_b),
         .o_idle   (lane_idle[g]),
         .i_take   (lane_take[g]),
         .o_done   (lane_done[g]),
         .o_result (lane_result[g])
      );
   end

   serial_collect #(
      .N_LANES (N_LANES)
   ) i_serial_collect (
      .clk           (clk),
      .i_rst         (i_rst),
      .i_lane_done   (lane_done),
      .i_lane_result (lane_result),
      .o_res_valid   (o_res_valid),
      .i_res_ready   (i_res_ready),
      .o_res_data    (o_res_data),
      .o_take        (lane_take)
   );

endmodule

// File: sim/tb_serial_cluster.sv
module tb_serial_cluster;

   localparam int N_LANES   = 4;
   localparam int MAX_VEC   = 64;
   localparam int CMD_LIMIT = 200;
   localparam int RES_LIMIT = 400;

   logic              clk;
   logic              rst;
   logic              cmd_valid;
   logic              cmd_ready;
   serial_pkg::op_t   cmd_op;
   serial_pkg::word_t cmd_a;
   serial_pkg::word_t cmd_b;
   logic              res_valid;
   logic              res_ready;
   serial_pkg::word_t res_data;

   // Four words per vector: op, a, b, expected
   logic [31:0] vec_mem [0:4*MAX_VEC-1];
   int          n_vec;
   int          pending[$];
   int          sent;
   int          results_seen;
   int          checks;
   int          errors;
   int          tests_run;
   int          ready_mode;
   integer      seed;

   serial_cluster #(
      .N_LANES (N_LANES)
   ) i_serial_cluster (
      .clk         (clk),
      .i_rst       (rst),
      .i_cmd_valid (cmd_valid),
      .o_cmd_ready (cmd_ready),
      .i_cmd_op    (cmd_op),
      .i_cmd_a     (cmd_a),
      .i_cmd_b     (cmd_b),
      .o_res_valid (res_valid),
      .i_res_ready (res_ready),
      .o_res_data  (res_data)
   );

   always #10 clk = ~clk;

   // Mode 0 stalls, 1 drains freely, 2 random back-pressure
   always @(posedge clk) begin
      #2;
      case (ready_mode)
         0:       res_ready = 1'b0;
         1:       res_ready = 1'b1;
         default: res_ready = 1'($random(seed));
      endcase
   end

   // A transfer seen mid-cycle completes on the next rising edge
   always @(negedge clk) begin : monitor
      int idx;
      if (!rst && res_valid && res_ready) begin
         results_seen++;
         checks++;
         assert (pending.size() > 0)
         else begin
            $display("[ERROR] t=%0t: result 0x%08h with no command outstanding", $time, res_data);
            errors++;
         end
         if (pending.size() > 0) begin
            idx = pending.pop_front();
            assert (res_data === vec_mem[4*idx+3])
            else begin
               $display("[ERROR] t=%0t: vector %0d op %0d got 0x%08h, expected 0x%08h",
                        $time, idx, vec_mem[4*idx], res_data, vec_mem[4*idx+3]);
               errors++;
            end
         end
      end
   end

   task automatic drive_vector(input int k);
      cmd_valid = 1'b1;
      cmd_op    = serial_pkg::op_t'(vec_mem[4*k][2:0]);
      cmd_a     = vec_mem[4*k+1];
      cmd_b     = vec_mem[4*k+2];
   endtask

   // Called a little after a rising edge, returns at the same phase
   task automatic send_vectors(input int first, input int count);
      int k;
      int cycles;
      for (k = first; k < first + count; k++) begin
         drive_vector(k);
         cycles = 0;
         @(negedge clk);
         while (!cmd_ready && cycles < CMD_LIMIT) begin
            @(negedge clk);
            cycles++;
         end
         if (cmd_ready) begin
            pending.push_back(k);
            sent++;
         end else begin
            $display("Command %0d was never accepted, the cluster stalled", k);
            errors++;
         end
         @(posedge clk);
         #2;
      end
      cmd_valid = 1'b0;
   endtask

   task automatic wait_results(input int target);
      int cycles;
      cycles = 0;
      while (results_seen < target && cycles < RES_LIMIT) begin
         @(posedge clk);
         cycles++;
      end
      if (results_seen < target) begin
         $display("Only %0d of %0d results came out, the cluster stalled", results_seen, target);
         errors++;
      end
      @(posedge clk);
      #2;
      checks++;
      // Once drained, no lane may still offer a result
      assert (pending.size() == 0 && !res_valid)
      else begin
         $display("[ERROR] t=%0t: %0d commands without a result, valid=%0b after drain",
                  $time, pending.size(), res_valid);
         errors++;
      end
   endtask

   task automatic set_ready_mode(input int mode);
      ready_mode = mode;
      @(posedge clk);
      #2;
   endtask

   task automatic report_test(input int num, input string name, input int errors_before);
      tests_run++;
      $display("Test %0d (%s): %s", num, name, (errors == errors_before) ? "ok" : "failed");
   endtask

   initial begin : main
      int k;
      int accepted;
      int err0;
      clk          = 1'b0;
      rst          = 1'b1;
      cmd_valid    = 1'b0;
      cmd_op       = serial_pkg::OP_ADD;
      cmd_a        = '0;
      cmd_b        = '0;
      res_ready    = 1'b0;
      ready_mode   = 0;
      seed         = 81;
      sent         = 0;
      results_seen = 0;
      checks       = 0;
      errors       = 0;
      tests_run    = 0;
      n_vec        = 0;
      $readmemh("sim/serial_cluster_input.txt", vec_mem);
      while (n_vec < MAX_VEC && !$isunknown(vec_mem[4*n_vec])) begin
         n_vec++;
      end
      if (n_vec < 17) begin
         $display("Too few vectors in the input file (%0d)", n_vec);
         errors++;
      end
      repeat (10) @(posedge clk);
      #2;
      rst = 1'b0;

      err0 = errors;
      @(negedge clk);
      checks++;
      assert (!res_valid && cmd_ready)
      else begin
         $display("[ERROR] t=%0t: after reset valid=%0b ready=%0b", $time, res_valid, cmd_ready);
         errors++;
      end
      @(posedge clk);
      #2;
      report_test(1, "reset state", err0);

      // One command at a time, each operation in isolation
      err0 = errors;
      set_ready_mode(1);
      for (k = 0; k < n_vec; k++) begin
         send_vectors(k, 1);
         wait_results(sent);
      end
      report_test(2, "all operations", err0);

      err0 = errors;
      send_vectors(0, 12);
      wait_results(sent);
      report_test(3, "back to back order", err0);

      // Results stalled, only one command per lane fits
      err0 = errors;
      set_ready_mode(0);
      accepted = 0;
      for (k = 0; k < 80; k++) begin
         drive_vector(12 + accepted);
         @(negedge clk);
         if (cmd_ready) begin
            pending.push_back(12 + accepted);
            accepted++;
            sent++;
         end
         @(posedge clk);
         #2;
      end
      cmd_valid = 1'b0;
      checks++;
      assert (accepted == N_LANES && !cmd_ready)
      else begin
         $display("[ERROR] t=%0t: %0d commands accepted while stalled, expected %0d",
                  $time, accepted, N_LANES);
         errors++;
      end
      set_ready_mode(1);
      wait_results(sent);
      report_test(4, "stall and release", err0);

      err0 = errors;
      set_ready_mode(2);
      send_vectors(0, n_vec);
      wait_results(sent);
      set_ready_mode(1);
      report_test(5, "random back-pressure", err0);

      $display("Tests: %0d  checks: %0d  results: %0d  errors: %0d",
               tests_run, checks, results_seen, errors);
      if (errors == 0) begin
         $display("STATUS: PASS");
      end else begin
         $display("STATUS: FAIL");
      end
      $finish;
   end

endmodule

// File: sources.f
source/serial_pkg.sv
source/serial_dispatch.sv
source/serial_lane.sv
source/serial_collect.sv
source/serial_cluster.sv
sim/tb_serial_cluster.sv

// File: Bender.yml
package:
  name: serial_cluster

sources:
  - source/serial_pkg.sv
  - source/serial_dispatch.sv
  - source/serial_lane.sv
  - source/serial_collect.sv
  - source/serial_cluster.sv
  - target: simulation
    files:
      - sim/tb_serial_cluster.sv

// File: sim/serial_cluster_input.txt
// Columns: op code, operand a, operand b, expected result (all hex)
// Op codes: 0 add, 1 sub, 2 and, 3 or, 4 xor, 5 slt, 6 sltu, 7 unused
0 00000001 FFFFFFFF 00000000
0 7FFFFFFF 00000001 80000000
0 12345678 87654321 99999999
0 FFFFFFFF FFFFFFFF FFFFFFFE
0 00000000 00000000 00000000
1 00000000 00000001 FFFFFFFF
1 80000000 00000001 7FFFFFFF
1 87654321 12345678 7530ECA9
1 00000005 00000005 00000000
1 FFFFFFFF 7FFFFFFF 80000000
2 F0F0F0F0 FF00FF00 F000F000
2 12345678 FFFFFFFF 12345678
2 AAAAAAAA 55555555 00000000
3 F0F0F0F0 0F0F0F0F FFFFFFFF
3 12340000 00005678 12345678
3 00000000 00000000 00000000
4 FFFF0000 0F0F0F0F F0F00F0F
4 12345678 12345678 00000000
4 AAAAAAAA FFFFFFFF 55555555
5 FFFFFFFF 00000001 00000001
5 00000001 FFFFFFFF 00000000
5 80000000 7FFFFFFF 00000001
5 7FFFFFFF 80000000 00000000
5 00000003 00000003 00000000
5 FFFFFFFE FFFFFFFF 00000001
5 00000002 00000005 00000001
6 FFFFFFFF 00000001 00000000
6 00000001 FFFFFFFF 00000001
6 80000000 7FFFFFFF 00000000
6 00000000 00000000 00000000
6 00000004 00000009 00000001
7 12345678 87654321 00000000
0 DEADBEEF 00000001 DEADBEF0
1 DEADBEEF DEADBEEF 00000000
4 DEADBEEF FFFFFFFF 21524110
3 DEADBEEF 00000000 DEADBEEF
